// ==== design/bpu.sv ====
`include "fetch_defs.svh"

module bpu import fetch_pkg::*; (
  input  logic             clk,
  input  logic             reset_i,
  input  logic [`XLEN-1:0] pc_i,
  input  predec_t          predec_i,
  input  logic             fetch_fire_i,
  ex_upd_if.slave          upd,
  input  logic [`XLEN-1:0] ras_top_i,
  output logic             ras_push_o,
  output logic             ras_pop_o,
  pred_if.master           pred
);

  localparam int IDX_W    = `BHT_IDX;
  localparam int BHT_SIZE = 1 << IDX_W;

  // 2-bit saturating counters
  logic [1:0]         bht_q [BHT_SIZE];
  // global history, resolved branches only
  logic [`HISLEN-1:0] ghr_q;

  logic [IDX_W-1:0]   rd_idx;
  logic [IDX_W-1:0]   wr_idx;
  logic [1:0]         wr_cnt;
  logic               predictable;
  logic               dir;
  logic [`XLEN-1:0]   tgt;

  // gshare hash, word pc xor history
  assign rd_idx = pc_i[`BHT_IDX+1:2] ^ IDX_W'(ghr_q);
  assign wr_idx = upd.upd_pc[`BHT_IDX+1:2] ^ IDX_W'(upd.upd_history);
  assign wr_cnt = bht_q[wr_idx];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      // weakly not-taken
      for (int i = 0; i < BHT_SIZE; i++) begin
        bht_q[i] <= 2'b01;
      end
      ghr_q <= '0;
    end else if (upd.upd_valid && upd.upd_jump_type == BRANCH) begin
      if (upd.upd_taken && wr_cnt != 2'b11) begin
        bht_q[wr_idx] <= wr_cnt + 2'd1;
      end else if (!upd.upd_taken && wr_cnt != 2'b00) begin
        bht_q[wr_idx] <= wr_cnt - 2'd1;
      end
      // newest outcome in the low bit
      ghr_q <= {ghr_q[`HISLEN-2:0], upd.upd_taken};
    end
  end

  // direction and target per jump type
  always_comb begin
    predictable = 1'b0;
    dir = 1'b0;
    tgt = predec_i.target;
    case (predec_i.jump_type)
      JAL: begin
        predictable = 1'b1;
        dir = 1'b1;
      end
      BRANCH: begin
        predictable = 1'b1;
        // counter msb says taken
        dir = bht_q[rd_idx][1];
      end
      JALR: begin
        // only returns, other indirect jumps left to ex
        if (predec_i.is_ret) begin
          predictable = 1'b1;
          dir = 1'b1;
          tgt = ras_top_i;
        end
      end
      default: begin
        predictable = 1'b0;
      end
    endcase
  end

  assign pred.pred_valid = fetch_fire_i & predictable;
  assign pred.pred_taken = dir;
  assign pred.pred_pc = tgt;
  assign pred.pred_history = ghr_q;

  // stack follows fired calls and returns
  assign ras_push_o = fetch_fire_i & predec_i.is_call;
  assign ras_pop_o = fetch_fire_i & predec_i.is_ret;

  // predecode never marks one word as both call and return
  a_push_pop_excl: assert property (@(posedge clk) disable iff (reset_i)
    !(ras_push_o && ras_pop_o));

endmodule

// ==== design/fetch_ctrl.sv ====
`include "fetch_defs.svh"

module fetch_ctrl (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 ex_redirect_i,
  input  logic [`XLEN-1:0]     ex_redirect_pc_i,
  input  logic                 id_stall_i,
  input  logic                 mem_stall_i,
  input  logic [`TRAP_LEN-1:0] trap_bus_i,
  pred_if.slave                pred,
  output logic [`XLEN-1:0]     pc_o,
  output logic                 fetch_fire_o,
  output logic                 if_stall_o,
  output logic                 if_flush_o
);

  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] pc_next;
  logic             hold;
  logic             pred_redirect;

  // memory wait or id back-pressure
  assign hold = mem_stall_i | id_stall_i;
  assign pred_redirect = pred.pred_valid & pred.pred_taken;

  // next pc priority, ex redirect first
  always_comb begin
    if (ex_redirect_i) begin
      pc_next = ex_redirect_pc_i;
    end else if (hold) begin
      pc_next = pc_q;
    end else if (pred_redirect) begin
      pc_next = pred.pred_pc;
    end else begin
      pc_next = pc_q + `XLEN'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q <= `RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

  // word leaves IF this cycle
  assign fetch_fire_o = ~mem_stall_i & ~id_stall_i & ~ex_redirect_i;
  // id holds IF/ID as is
  assign if_stall_o = id_stall_i;
  // bubble on redirect, or memory wait unless id is holding
  assign if_flush_o = ex_redirect_i | (mem_stall_i & ~id_stall_i);

  // an aligned pc is the only way a fetch fires without the misaligned bit
  a_fire_aligned: assert property (@(posedge clk) disable iff (reset_i)
    fetch_fire_o && !trap_bus_i[`TRAP_INST_ADDR_MISALIGNED] |-> pc_o[1:0] == 2'b00);

endmodule

// ==== design/fetch_defs.svh ====
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// address and data width
`define XLEN 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// gshare sizing
`define HISLEN 6
`define BHT_IDX 6

// return stack entries, power of two
`define RAS_DEPTH 4

// fetch trap bus layout
`define TRAP_LEN 3
`define TRAP_INST_ADDR_MISALIGNED 0
`define TRAP_INST_ACCESS_FAULT 1
`define TRAP_INST_PAGE_FAULT 2

`endif

// ==== design/fetch_ifc.sv ====
`include "fetch_defs.svh"

// prediction for the word fetched this cycle
interface pred_if ();
  logic               pred_valid;
  logic               pred_taken;
  logic [`XLEN-1:0]   pred_pc;
  // history used for the lookup, travels with the instruction
  logic [`HISLEN-1:0] pred_history;

  modport master (
    output pred_valid, pred_taken, pred_pc, pred_history
  );

  modport slave (
    input pred_valid, pred_taken, pred_pc, pred_history
  );
endinterface

// resolved branch info coming back from ex
interface ex_upd_if import fetch_pkg::*; ();
  logic               upd_valid;
  logic               upd_taken;
  logic [`XLEN-1:0]   upd_pc;
  logic [`HISLEN-1:0] upd_history;
  jump_type_e         upd_jump_type;

  modport master (
    output upd_valid, upd_taken, upd_pc, upd_history, upd_jump_type
  );

  modport slave (
    input upd_valid, upd_taken, upd_pc, upd_history, upd_jump_type
  );
endinterface

// ==== design/fetch_pkg.sv ====
`include "fetch_defs.svh"

package fetch_pkg;

  // control flow class from predecode
  typedef enum logic [1:0] {
    NONE   = 2'b00,
    JAL    = 2'b01,
    JALR   = 2'b10,
    BRANCH = 2'b11
  } jump_type_e;

  // jal layout, imm scattered over the upper bits
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // branch layout, also gives rs1 for jalr
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  // same fetched word, two views
  typedef union packed {
    j_fmt_t j;
    b_fmt_t b;
  } inst_word_u;

  typedef struct packed {
    jump_type_e        jump_type;
    logic              is_call;
    logic              is_ret;
    // pc plus decoded immediate
    logic [`XLEN-1:0]  target;
  } predec_t;

endpackage

// ==== design/fetch_top.sv ====
`include "fetch_defs.svh"

module fetch_top import fetch_pkg::*; (
  input  logic                 clk,
  input  logic                 reset_i,
  // instruction memory, same-cycle reply
  output logic [`XLEN-1:0]     imem_addr_o,
  input  logic [`XLEN-1:0]     imem_rdata_i,
  input  logic                 imem_valid_i,
  input  logic                 imem_err_i,
  input  logic                 lsu_busy_i,
  input  logic                 id_stall_i,
  input  logic                 ex_redirect_i,
  input  logic [`XLEN-1:0]     ex_redirect_pc_i,
  // resolved branch from ex
  input  logic                 ex_upd_valid_i,
  input  logic                 ex_upd_taken_i,
  input  logic [`XLEN-1:0]     ex_upd_pc_i,
  input  logic [`HISLEN-1:0]   ex_upd_history_i,
  input  logic [1:0]           ex_upd_jump_type_i,
  output logic                 if_stall_o,
  output logic                 ifid_valid_o,
  output logic [`XLEN-1:0]     ifid_pc_o,
  output logic [`XLEN-1:0]     ifid_inst_o,
  output logic [`TRAP_LEN-1:0] ifid_trap_o,
  output logic [`XLEN-1:0]     bpu_pc_o,
  output logic                 bpu_pc_valid_o,
  output logic                 ifid_pred_taken_o,
  output logic [`HISLEN-1:0]   ifid_history_o
);

  logic [`XLEN-1:0]     pc;
  logic                 fetch_fire;
  logic                 mem_stall;
  logic                 hold_ifid;
  logic                 flush_ifid;
  logic [`TRAP_LEN-1:0] trap_bus;
  predec_t              predec;
  logic                 ras_push;
  logic                 ras_pop;
  logic [`XLEN-1:0]     ras_top;
  logic [`XLEN-1:0]     link_pc;

  pred_if   pred ();
  ex_upd_if ex_upd ();

  assign ex_upd.upd_valid = ex_upd_valid_i;
  assign ex_upd.upd_taken = ex_upd_taken_i;
  assign ex_upd.upd_pc = ex_upd_pc_i;
  assign ex_upd.upd_history = ex_upd_history_i;
  assign ex_upd.upd_jump_type = jump_type_e'(ex_upd_jump_type_i);

  assign imem_addr_o = pc;
  // return address of a call
  assign link_pc = pc + `XLEN'd4;
  assign bpu_pc_o = pred.pred_pc;
  assign bpu_pc_valid_o = pred.pred_valid & pred.pred_taken;

  fetch_ctrl u_ctrl (.clk(clk), .reset_i(reset_i), .ex_redirect_i(ex_redirect_i),
    .ex_redirect_pc_i(ex_redirect_pc_i), .id_stall_i(id_stall_i), .mem_stall_i(mem_stall),
    .trap_bus_i(trap_bus), .pred(pred.slave), .pc_o(pc), .fetch_fire_o(fetch_fire),
    .if_stall_o(hold_ifid), .if_flush_o(flush_ifid));

  ifu u_ifu (.pc_i(pc), .imem_rdata_i(imem_rdata_i), .imem_valid_i(imem_valid_i),
    .imem_err_i(imem_err_i), .lsu_busy_i(lsu_busy_i), .mem_stall_o(mem_stall),
    .stall_req_o(if_stall_o), .predec_o(predec), .trap_bus_o(trap_bus));

  bpu u_bpu (.clk(clk), .reset_i(reset_i), .pc_i(pc), .predec_i(predec),
    .fetch_fire_i(fetch_fire), .upd(ex_upd.slave), .ras_top_i(ras_top),
    .ras_push_o(ras_push), .ras_pop_o(ras_pop), .pred(pred.master));

  ras u_ras (.clk(clk), .reset_i(reset_i), .push_i(ras_push), .push_data_i(link_pc),
    .pop_i(ras_pop), .top_o(ras_top));

  if_id_reg u_ifid (.clk(clk), .reset_i(reset_i), .stall_i(hold_ifid), .flush_i(flush_ifid),
    .pc_i(pc), .inst_i(imem_rdata_i), .trap_bus_i(trap_bus), .pred(pred.slave),
    .valid_o(ifid_valid_o), .pc_o(ifid_pc_o), .inst_o(ifid_inst_o),
    .trap_bus_o(ifid_trap_o), .pred_taken_o(ifid_pred_taken_o),
    .history_o(ifid_history_o));

endmodule

// ==== design/if_id_reg.sv ====
`include "fetch_defs.svh"

module if_id_reg (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 stall_i,
  input  logic                 flush_i,
  input  logic [`XLEN-1:0]     pc_i,
  input  logic [`XLEN-1:0]     inst_i,
  input  logic [`TRAP_LEN-1:0] trap_bus_i,
  pred_if.slave                pred,
  output logic                 valid_o,
  output logic [`XLEN-1:0]     pc_o,
  output logic [`XLEN-1:0]     inst_o,
  output logic [`TRAP_LEN-1:0] trap_bus_o,
  output logic                 pred_taken_o,
  output logic [`HISLEN-1:0]   history_o
);

  // control bits, bubble clears them
  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      valid_o <= 1'b0;
      trap_bus_o <= '0;
      pred_taken_o <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= 1'b1;
      trap_bus_o <= trap_bus_i;
      pred_taken_o <= pred.pred_valid & pred.pred_taken;
    end
  end

  // payload, held only while id stalls
  always_ff @(posedge clk) begin
    if (flush_i || !stall_i) begin
      pc_o <= pc_i;
      inst_o <= inst_i;
      history_o <= pred.pred_history;
    end
  end

endmodule

// ==== design/ifu.sv ====
`include "fetch_defs.svh"

module ifu import fetch_pkg::*; (
  input  logic [`XLEN-1:0]     pc_i,
  input  logic [`XLEN-1:0]     imem_rdata_i,
  input  logic                 imem_valid_i,
  input  logic                 imem_err_i,
  input  logic                 lsu_busy_i,
  output logic                 mem_stall_o,
  output logic                 stall_req_o,
  output predec_t              predec_o,
  output logic [`TRAP_LEN-1:0] trap_bus_o
);

  inst_word_u       inst;
  logic [`XLEN-1:0] imm_j;
  logic [`XLEN-1:0] imm_b;

  assign inst = imem_rdata_i;

  // memory not ready, pc must wait
  assign mem_stall_o = ~imem_valid_i;
  // lsu reports the stall itself while busy
  assign stall_req_o = lsu_busy_i ? 1'b0 : mem_stall_o;

  // sign-extended jal offset
  assign imm_j = {{12{inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11,
                  inst.j.imm10_1, 1'b0};
  // sign-extended branch offset
  assign imm_b = {{20{inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5,
                  inst.b.imm4_1, 1'b0};

  always_comb begin
    predec_o = '0;
    predec_o.jump_type = NONE;
    case (inst.j.opcode)
      7'b1101111: begin
        predec_o.jump_type = JAL;
        // link to ra
        predec_o.is_call = (inst.j.rd == 5'd1);
        predec_o.target = pc_i + imm_j;
      end
      7'b1100111: begin
        if (inst.b.funct3 == 3'b000) begin
          predec_o.jump_type = JALR;
          // jalr x0, 0(ra)
          predec_o.is_ret = (inst.b.rs1 == 5'd1) && (inst.j.rd == 5'd0);
        end
      end
      7'b1100011: begin
        predec_o.jump_type = BRANCH;
        predec_o.target = pc_i + imm_b;
      end
      default: begin
        predec_o.jump_type = NONE;
      end
    endcase
  end

  // no compressed, so anything off a word boundary
  always_comb begin
    trap_bus_o = '0;
    trap_bus_o[`TRAP_INST_ADDR_MISALIGNED] = |pc_i[1:0];
    trap_bus_o[`TRAP_INST_ACCESS_FAULT] = imem_err_i;
    // no mmu
    trap_bus_o[`TRAP_INST_PAGE_FAULT] = 1'b0;
  end

endmodule

// ==== design/ras.sv ====
`include "fetch_defs.svh"

module ras (
  input  logic             clk,
  input  logic             reset_i,
  input  logic             push_i,
  input  logic [`XLEN-1:0] push_data_i,
  input  logic             pop_i,
  output logic [`XLEN-1:0] top_o
);

  localparam int PTR_W = $clog2(`RAS_DEPTH);

  logic [`XLEN-1:0] stack_q [`RAS_DEPTH];
  // next free slot
  logic [PTR_W-1:0] sp_q;
  logic [PTR_W-1:0] top_idx;

  // top sits just below sp, wraps on underflow
  assign top_idx = sp_q - 1'b1;
  assign top_o = stack_q[top_idx];

  // pointer wraps, oldest entry overwritten on overflow
  always_ff @(posedge clk) begin
    if (reset_i) begin
      sp_q <= '0;
    end else if (push_i) begin
      sp_q <= sp_q + 1'b1;
    end else if (pop_i) begin
      sp_q <= sp_q - 1'b1;
    end
  end

  // entries
  always_ff @(posedge clk) begin
    if (push_i) begin
      stack_q[sp_q] <= push_data_i;
    end
  end

endmodule

// ==== files.f ====
+incdir+design
+incdir+test
design/fetch_pkg.sv
design/fetch_ifc.sv
design/fetch_ctrl.sv
design/ifu.sv
design/bpu.sv
design/ras.sv
design/if_id_reg.sv
design/fetch_top.sv
test/tb_fetch.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_fetch \
  -o tb_fetch_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0

// ==== test/tb_fetch_model.svh ====
`ifndef TB_FETCH_MODEL_SVH
`define TB_FETCH_MODEL_SVH

// sign-extended J-type offset, straight from the ISA bit layout
function automatic logic [31:0] imm_j_ref(input logic [31:0] w);
  return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
endfunction

// sign-extended B-type offset
function automatic logic [31:0] imm_b_ref(input logic [31:0] w);
  return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
endfunction

// 0 none, 1 jal, 2 jalr, 3 branch
function automatic logic [1:0] jtype_ref(input logic [31:0] w);
  if (w[6:0] == 7'h6f) return 2'd1;
  if (w[6:0] == 7'h67 && w[14:12] == 3'd0) return 2'd2;
  if (w[6:0] == 7'h63) return 2'd3;
  return 2'd0;
endfunction

// jal linking to ra
function automatic logic is_call_ref(input logic [31:0] w);
  return jtype_ref(w) == 2'd1 && w[11:7] == 5'd1;
endfunction

// jalr x0, 0(ra)
function automatic logic is_ret_ref(input logic [31:0] w);
  return jtype_ref(w) == 2'd2 && w[19:15] == 5'd1 && w[11:7] == 5'd0;
endfunction

function automatic logic [31:0] target_ref(input logic [31:0] pc, input logic [31:0] w);
  if (jtype_ref(w) == 2'd1) return pc + imm_j_ref(w);
  if (jtype_ref(w) == 2'd3) return pc + imm_b_ref(w);
  return 32'd0;
endfunction

// two-bit saturating counter
function automatic logic [1:0] cnt_next_ref(input logic [1:0] c, input logic taken);
  if (taken) return (c == 2'b11) ? c : c + 2'd1;
  return (c == 2'b00) ? c : c - 2'd1;
endfunction

function automatic logic [5:0] bht_index_ref(input logic [31:0] pc, input logic [5:0] h);
  return pc[7:2] ^ h;
endfunction

function automatic logic [2:0] trap_ref(input logic [31:0] pc, input logic err);
  // page fault never, no mmu
  return {1'b0, err, |pc[1:0]};
endfunction

// redirect, then hold, then taken prediction, then sequential
function automatic logic [31:0] next_pc_ref(input logic [31:0] pc, input logic redir,
    input logic [31:0] rpc, input logic hold, input logic hit, input logic [31:0] tgt);
  if (redir) return rpc;
  if (hold) return pc;
  if (hit) return tgt;
  return pc + 32'd4;
endfunction

`endif

// ==== test/tb_fetch.sv ====
`include "fetch_defs.svh"

module tb_fetch;
  timeunit 1ns;
  timeprecision 1ps;

  // roughly three times the summed test lengths
  localparam int MAX_CYCLES = 400;

  logic clk, reset_i, imem_valid, imem_err, lsu_busy, id_stall, redir;
  logic [31:0] imem_addr, imem_rdata, redir_pc, upd_pc, ifid_pc, ifid_inst, bpu_pc;
  logic upd_valid, upd_taken, if_stall, ifid_valid, bpu_pc_valid, ifid_ptaken;
  logic [5:0] upd_hist, ifid_hist;
  logic [1:0] upd_type;
  logic [2:0] ifid_trap;
  logic [31:0] mem [256];
  // model state
  logic [31:0] m_pc, m_ifpc, m_inst;
  logic [1:0] m_bht [64];
  logic [5:0] m_ghr, m_hist;
  logic [31:0] m_stack [4];
  logic [1:0] m_sp;
  logic m_valid, m_ptaken;
  logic [2:0] m_trap;
  int err_cnt = 0;
  int chk_cnt = 0;
  int cycles = 0;

  `include "tb_fetch_model.svh"

  fetch_top i_dut (.clk(clk), .reset_i(reset_i), .imem_addr_o(imem_addr),
    .imem_rdata_i(imem_rdata), .imem_valid_i(imem_valid), .imem_err_i(imem_err),
    .lsu_busy_i(lsu_busy), .id_stall_i(id_stall), .ex_redirect_i(redir),
    .ex_redirect_pc_i(redir_pc), .ex_upd_valid_i(upd_valid), .ex_upd_taken_i(upd_taken),
    .ex_upd_pc_i(upd_pc), .ex_upd_history_i(upd_hist), .ex_upd_jump_type_i(upd_type),
    .if_stall_o(if_stall), .ifid_valid_o(ifid_valid), .ifid_pc_o(ifid_pc),
    .ifid_inst_o(ifid_inst), .ifid_trap_o(ifid_trap), .bpu_pc_o(bpu_pc),
    .bpu_pc_valid_o(bpu_pc_valid), .ifid_pred_taken_o(ifid_ptaken),
    .ifid_history_o(ifid_hist));

  // same-cycle memory reply
  assign imem_rdata = mem[imem_addr[9:2]];

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [31:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // beq x0, x0 with the given offset
  function automatic logic [31:0] enc_beq(input logic [31:0] imm);
    return {imm[12], imm[10:5], 10'd0, 3'd0, imm[4:1], imm[11], 7'h63};
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    assert (got === exp) else begin
      $display("** Error at %0d ns: %s expected %h got %h", $time, name, exp, got);
      err_cnt++;
    end
  endtask

  task automatic predict_ref(input logic [31:0] pc, input logic [31:0] w, input logic fire,
      output logic hit, output logic [31:0] tgt);
    logic taken;
    taken = 1'b0;
    tgt = target_ref(pc, w);
    case (jtype_ref(w))
      2'd1: taken = 1'b1;
      2'd3: taken = m_bht[bht_index_ref(pc, m_ghr)][1];
      2'd2: begin
        if (is_ret_ref(w)) begin
          taken = 1'b1;
          tgt = m_stack[2'(m_sp - 2'd1)];
        end
      end
      default: taken = 1'b0;
    endcase
    hit = fire & taken;
  endtask

  // advance the model by one rising edge
  task automatic model_edge();
    logic [31:0] w;
    logic [31:0] tgt;
    logic fire, hit, flush;
    if (reset_i) begin
      m_pc = `RESET_PC;
      m_ghr = '0;
      m_sp = '0;
      m_valid = 1'b0;
      m_trap = '0;
      m_ptaken = 1'b0;
      for (int i = 0; i < 64; i++) begin
        m_bht[i] = 2'b01;
      end
    end else begin
      w = mem[m_pc[9:2]];
      fire = imem_valid & ~id_stall & ~redir;
      predict_ref(m_pc, w, fire, hit, tgt);
      flush = redir | (~imem_valid & ~id_stall);
      if (flush) begin
        m_valid = 1'b0;
        m_trap = '0;
        m_ptaken = 1'b0;
      end else if (!id_stall) begin
        m_valid = 1'b1;
        m_trap = trap_ref(m_pc, imem_err);
        m_ptaken = hit;
      end
      if (flush || !id_stall) begin
        m_ifpc = m_pc;
        m_inst = w;
        m_hist = m_ghr;
      end
      if (fire && is_call_ref(w)) begin
        m_stack[m_sp] = m_pc + 32'd4;
        m_sp = m_sp + 2'd1;
      end else if (fire && is_ret_ref(w)) begin
        m_sp = m_sp - 2'd1;
      end
      if (upd_valid && upd_type == 2'd3) begin
        m_bht[bht_index_ref(upd_pc, upd_hist)] =
          cnt_next_ref(m_bht[bht_index_ref(upd_pc, upd_hist)], upd_taken);
        m_ghr = {m_ghr[4:0], upd_taken};
      end
      m_pc = next_pc_ref(m_pc, redir, redir_pc, ~imem_valid | id_stall, hit, tgt);
    end
  endtask

  // registered outputs checked after the edge and combinational ones after the input change
  always begin
    logic hit;
    logic [31:0] tgt;
    @(posedge clk);
    model_edge();
    #1;
    if (!reset_i) begin
      check_val("imem_addr_o", imem_addr, m_pc);
      check_val("ifid_valid_o", 32'(ifid_valid), 32'(m_valid));
      check_val("ifid_pc_o", ifid_pc, m_ifpc);
      check_val("ifid_inst_o", ifid_inst, m_inst);
      check_val("ifid_trap_o", 32'(ifid_trap), 32'(m_trap));
      check_val("ifid_pred_taken_o", 32'(ifid_ptaken), 32'(m_ptaken));
      check_val("ifid_history_o", 32'(ifid_hist), 32'(m_hist));
    end
    @(negedge clk);
    #1;
    if (!reset_i) begin
      predict_ref(m_pc, mem[m_pc[9:2]], imem_valid & ~id_stall & ~redir, hit, tgt);
      check_val("if_stall_o", 32'(if_stall), 32'(!lsu_busy && !imem_valid));
      check_val("bpu_pc_valid_o", 32'(bpu_pc_valid), 32'(hit));
      if (hit) check_val("bpu_pc_o", bpu_pc, tgt);
    end
  end

  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Test failed");
    $finish;
  end

  // drive one cycle of inputs on the falling edge
  task automatic drive(input logic v, input logic err, input logic lsu, input logic ids,
      input logic rd, input logic [31:0] rpc);
    @(negedge clk);
    imem_valid = v;
    imem_err = err;
    lsu_busy = lsu;
    id_stall = ids;
    redir = rd;
    redir_pc = rpc;
    upd_valid = 1'b0;
  endtask

  task automatic end_test(input string name, input int err_before);
    $display("test %s: %0d errors", name, err_cnt - err_before);
  endtask

  initial begin
    int e0;
    void'($urandom(18220));
    // nop fill tagged with the word address
    for (int i = 0; i < 256; i++) begin
      mem[i] = {17'd0, 8'(i), 7'h13};
    end
    mem[32'h100 >> 2] = enc_jal(5'd1, 32'h40);
    mem[32'h144 >> 2] = 32'h0000_8067;
    mem[32'h104 >> 2] = enc_jal(5'd1, 32'h80);
    mem[32'h184 >> 2] = 32'h0000_8067;
    mem[32'h200 >> 2] = enc_beq(32'h20);
    mem[32'h220 >> 2] = enc_jal(5'd0, -32'sd32);
    reset_i = 1'b1;
    {imem_valid, imem_err, lsu_busy, id_stall, redir, upd_valid, upd_taken} = '0;
    {redir_pc, upd_pc, upd_hist, upd_type} = '0;
    // five rising edges in reset
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;

    e0 = err_cnt;
    for (int i = 0; i < 20; i++) drive(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 32'd0);
    end_test("straight_line", e0);

    e0 = err_cnt;
    for (int i = 0; i < 30; i++) begin
      drive(1'($urandom % 2), 1'b0, (i >= 15) ? 1'($urandom % 2) : 1'b0, 1'b0, 1'b0, 32'd0);
    end
    end_test("mem_stall", e0);

    e0 = err_cnt;
    drive(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 32'h100);
    for (int i = 0; i < 14; i++) drive(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 32'd0);
    end_test("call_return", e0);

    e0 = err_cnt;
    drive(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 32'h200);
    for (int i = 0; i < 40; i++) begin
      drive(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 32'd0);
      // mostly taken so the counters climb
      upd_valid = 1'($urandom % 2);
      upd_taken = ($urandom % 4) != 0;
      upd_pc = 32'h200;
      upd_hist = m_ghr;
      upd_type = 2'd3;
    end
    end_test("gshare", e0);

    e0 = err_cnt;
    drive(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 32'h302);
    for (int i = 0; i < 6; i++) drive(1'b1, 1'($urandom % 2), 1'b0, 1'b0, 1'b0, 32'd0);
    drive(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 32'h3a0);
    for (int i = 0; i < 4; i++) drive(1'b1, 1'($urandom % 2), 1'b0, 1'b0, 1'b0, 32'd0);
    end_test("redirect", e0);

    e0 = err_cnt;
    for (int i = 0; i < 10; i++) drive(1'($urandom % 2), 1'b0, 1'b0, 1'b1, 1'b0, 32'd0);
    for (int i = 0; i < 4; i++) drive(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 32'd0);
    end_test("id_stall", e0);

    // let the last checks land
    repeat (2) @(negedge clk);
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
